// File: core_pkg.sv
// Instruction set definitions
package core_pkg;

    localparam int xlen      = 32;                 // Data path width
    localparam int imm_w     = 12;                 // Immediate field width
    localparam int mem_words = 16;                 // Data memory depth
    localparam int mem_aw    = $clog2(mem_words);  // Word address bits

    typedef logic [4:0] reg_addr_t;

    // Three-bit operation codes
    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_and  = 3'd2,
        op_xor  = 3'd3,
        op_addi = 3'd4,
        op_mul  = 3'd5,  // Iterative, variable latency
        op_ld   = 3'd6,
        op_st   = 3'd7   // No register write
    } op_e;

    typedef struct packed {
        op_e                     op;
        reg_addr_t               rd;
        reg_addr_t               rs1;
        reg_addr_t               rs2;
        logic signed [imm_w-1:0] imm;
    } instr_t;

endpackage

// File: pipe_pkg.sv
// Pipeline structure definitions
package pipe_pkg;

    localparam int n_stages = 4;

    typedef enum logic [1:0] {
        stg_fetch  = 2'd0,
        stg_decode = 2'd1,
        stg_exec   = 2'd2,
        stg_wb     = 2'd3
    } stage_e;

    typedef enum logic [1:0] {
        fwd_none = 2'd0,  // Register file value
        fwd_exec = 2'd1,
        fwd_wb   = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        core_pkg::op_e                     op;
        core_pkg::reg_addr_t               rd;
        logic                              wr;       // Writes rd
        logic [core_pkg::xlen-1:0]         opa;
        logic [core_pkg::xlen-1:0]         opb;
        logic signed [core_pkg::imm_w-1:0] imm;
        logic [core_pkg::xlen-1:0]         st_data;
    } dx_t;

    typedef struct packed {
        core_pkg::reg_addr_t       rd;
        logic                      wr;
        logic                      is_load;  // Result replaced by memory data
        logic [core_pkg::xlen-1:0] result;
    } xw_t;

    typedef struct packed {
        logic                      valid;
        core_pkg::reg_addr_t       rd;
        logic [core_pkg::xlen-1:0] data;
    } wb_t;

endpackage

// File: hazard_ctrl.sv
// Hazard and pipeline control
`timescale 1ns/1ps

module hazard_ctrl (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                mispredict_i,
    input  logic                fetch_ready_i,   // Decode holds a valid instruction
    input  core_pkg::reg_addr_t dec_rs1_i,
    input  core_pkg::reg_addr_t dec_rs2_i,
    input  logic                ex_wr_i,
    input  core_pkg::reg_addr_t ex_rd_i,
    input  logic                ex_ready_i,      // Low while a multi-cycle op runs
    input  logic                ex_fwd_valid_i,  // Low for a load in execute
    input  logic                wb_wr_i,
    input  core_pkg::reg_addr_t wb_rd_i,
    output pipe_pkg::fwd_sel_e  fwd_sel1_o,
    output pipe_pkg::fwd_sel_e  fwd_sel2_o,
    output logic                fetch_stall_o,
    output logic                fetch_flush_o,
    output logic                dec_stall_o,
    output logic                dec_flush_o
);
    import pipe_pkg::*;

    logic [n_stages-1:0] invalid_q;  // Indexed by stage_e
    logic                start_q;
    logic                flush;
    logic                ex_fwd1;
    logic                ex_fwd2;
    logic                wb_fwd1;
    logic                wb_fwd2;

    // Bubbles never forward
    assign ex_fwd1 = ex_wr_i && (dec_rs1_i == ex_rd_i) && (dec_rs1_i != '0)
                     && !invalid_q[stg_exec];
    assign ex_fwd2 = ex_wr_i && (dec_rs2_i == ex_rd_i) && (dec_rs2_i != '0)
                     && !invalid_q[stg_exec];
    assign wb_fwd1 = wb_wr_i && (dec_rs1_i == wb_rd_i) && (dec_rs1_i != '0)
                     && !invalid_q[stg_wb];
    assign wb_fwd2 = wb_wr_i && (dec_rs2_i == wb_rd_i) && (dec_rs2_i != '0)
                     && !invalid_q[stg_wb];

    assign fwd_sel1_o = ex_fwd1 ? fwd_exec : (wb_fwd1 ? fwd_wb : fwd_none);  // Execute first
    assign fwd_sel2_o = ex_fwd2 ? fwd_exec : (wb_fwd2 ? fwd_wb : fwd_none);

    assign fetch_stall_o = !ex_ready_i || (!ex_fwd_valid_i && (ex_fwd1 || ex_fwd2));
    assign dec_stall_o   = fetch_stall_o || !fetch_ready_i;

    assign flush         = mispredict_i || start_q;
    assign fetch_flush_o = flush;
    assign dec_flush_o   = flush;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            invalid_q <= '1;
            start_q   <= 1'b1;  // One flush cycle after reset
        end else begin
            start_q               <= 1'b0;
            invalid_q[stg_fetch]  <= 1'b0;
            if (flush) begin
                invalid_q[stg_decode] <= 1'b1;
            end else if (!fetch_stall_o) begin
                invalid_q[stg_decode] <= invalid_q[stg_fetch];
            end
            // Execute keeps its entry while busy
            if (ex_ready_i) begin
                invalid_q[stg_exec] <= (flush || dec_stall_o) ? 1'b1 : invalid_q[stg_decode];
            end
            invalid_q[stg_wb] <= invalid_q[stg_exec] || !ex_ready_i;
        end
    end

endmodule

// File: stage_reg.sv
// Pipeline stage register
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     hold_i,     // Keep current contents
    input  logic     kill_i,     // Drop the stage entry
    input  payload_t d_i,
    input  logic     d_valid_i,
    output payload_t q_o,
    output logic     q_valid_o
);

    // Kill wins over hold so a flush reaches a stalled stage
    always_ff @(posedge clk_i) begin
        if (rst_i || kill_i) begin
            q_valid_o <= 1'b0;
        end else if (!hold_i) begin
            q_valid_o <= d_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!hold_i) begin
            q_o <= d_i;
        end
    end

endmodule

// File: reg_file.sv
// Integer register file
`timescale 1ns/1ps

module reg_file (
    input  logic                      clk_i,
    input  core_pkg::reg_addr_t       rd_addr1_i,
    input  core_pkg::reg_addr_t       rd_addr2_i,
    input  pipe_pkg::wb_t             wb_i,
    output logic [core_pkg::xlen-1:0] rd_data1_o,
    output logic [core_pkg::xlen-1:0] rd_data2_o
);
    import core_pkg::*;

    localparam int n_regs = 2 ** $bits(reg_addr_t);

    logic [xlen-1:0] regs [n_regs];

    always_ff @(posedge clk_i) begin
        if (wb_i.valid) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // x0 is hardwired to zero
    assign rd_data1_o = (rd_addr1_i == '0) ? '0 : regs[rd_addr1_i];
    assign rd_data2_o = (rd_addr2_i == '0) ? '0 : regs[rd_addr2_i];

endmodule

// File: decode_stage.sv
// Decode and operand select
`timescale 1ns/1ps

module decode_stage (
    input  core_pkg::instr_t          instr_i,
    input  logic                      instr_valid_i,
    input  logic [core_pkg::xlen-1:0] rf_data1_i,
    input  logic [core_pkg::xlen-1:0] rf_data2_i,
    input  pipe_pkg::fwd_sel_e        fwd_sel1_i,
    input  pipe_pkg::fwd_sel_e        fwd_sel2_i,
    input  logic [core_pkg::xlen-1:0] ex_result_i,
    input  logic [core_pkg::xlen-1:0] wb_data_i,
    output core_pkg::reg_addr_t       rs1_o,
    output core_pkg::reg_addr_t       rs2_o,
    output pipe_pkg::dx_t             dx_o
);
    import core_pkg::*;
    import pipe_pkg::*;

    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;

    function automatic logic [xlen-1:0] pick_operand(
        input fwd_sel_e        sel,
        input logic [xlen-1:0] rf_val,
        input logic [xlen-1:0] ex_val,
        input logic [xlen-1:0] wb_val
    );
        case (sel)
            fwd_exec: return ex_val;
            fwd_wb:   return wb_val;
            default:  return rf_val;
        endcase
    endfunction

    assign rs1_o = instr_i.rs1;
    assign rs2_o = instr_i.rs2;

    assign op1 = pick_operand(fwd_sel1_i, rf_data1_i, ex_result_i, wb_data_i);
    assign op2 = pick_operand(fwd_sel2_i, rf_data2_i, ex_result_i, wb_data_i);

    always_comb begin
        dx_o.op      = instr_i.op;
        dx_o.rd      = instr_i.rd;
        // Stores and x0 targets never write back
        dx_o.wr      = instr_valid_i && (instr_i.op != op_st) && (instr_i.rd != '0);
        dx_o.opa     = op1;
        dx_o.opb     = op2;
        dx_o.imm     = instr_i.imm;
        dx_o.st_data = op2;  // Store data comes from rs2
    end

endmodule

// File: exec_unit.sv
// Execute unit with iterative multiplier
`timescale 1ns/1ps

module exec_unit (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  pipe_pkg::dx_t               dx_i,
    input  logic                        dx_valid_i,
    output pipe_pkg::xw_t               xw_o,
    output logic                        ready_o,
    output logic                        fwd_valid_o,
    output logic [core_pkg::xlen-1:0]   result_o,
    output logic                        mem_we_o,
    output logic [core_pkg::mem_aw-1:0] mem_addr_o,
    output logic [core_pkg::xlen-1:0]   mem_wdata_o
);
    import core_pkg::*;

    logic            is_mul;
    logic            mul_busy_q;
    logic            mul_done_q;
    logic [xlen-1:0] acc_q;
    logic [xlen-1:0] mcand_q;
    logic [xlen-1:0] mplier_q;
    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] addr_sum;
    logic [xlen-1:0] alu_res;

    assign is_mul   = dx_valid_i && (dx_i.op == op_mul);
    assign imm_ext  = {{(xlen-imm_w){dx_i.imm[imm_w-1]}}, dx_i.imm};
    assign addr_sum = dx_i.opa + imm_ext;  // ADDI and memory address

    always_comb begin
        case (dx_i.op)
            op_add:  alu_res = dx_i.opa + dx_i.opb;
            op_sub:  alu_res = dx_i.opa - dx_i.opb;
            op_and:  alu_res = dx_i.opa & dx_i.opb;
            op_xor:  alu_res = dx_i.opa ^ dx_i.opb;
            op_mul:  alu_res = acc_q;
            default: alu_res = addr_sum;
        endcase
    end

    // Shift-and-add, stops once no multiplier bits remain
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mul_busy_q <= 1'b0;
            mul_done_q <= 1'b0;
        end else if (is_mul && !mul_busy_q && !mul_done_q) begin
            mul_busy_q <= 1'b1;
        end else if (mul_busy_q) begin
            if (mplier_q[xlen-1:1] == '0) begin
                mul_busy_q <= 1'b0;
                mul_done_q <= 1'b1;  // Product ready next cycle
            end
        end else begin
            mul_done_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (is_mul && !mul_busy_q && !mul_done_q) begin
            acc_q    <= '0;
            mcand_q  <= dx_i.opa;
            mplier_q <= dx_i.opb;
        end else if (mul_busy_q) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign ready_o     = !(is_mul && !mul_done_q);
    assign fwd_valid_o = !(dx_valid_i && (dx_i.op == op_ld));  // Load data only in writeback
    assign result_o    = alu_res;
    assign mem_we_o    = dx_valid_i && (dx_i.op == op_st);
    assign mem_addr_o  = addr_sum[mem_aw-1:0];  // Wraps within memory depth
    assign mem_wdata_o = dx_i.st_data;

    always_comb begin
        xw_o.rd      = dx_i.rd;
        xw_o.wr      = dx_i.wr;
        xw_o.is_load = (dx_i.op == op_ld);
        xw_o.result  = alu_res;
    end

endmodule

// File: data_mem.sv
// Word-addressed data memory
`timescale 1ns/1ps

module data_mem (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        we_i,
    input  logic [core_pkg::mem_aw-1:0] addr_i,
    input  logic [core_pkg::xlen-1:0]   wdata_i,
    output logic [core_pkg::xlen-1:0]   rdata_o
);
    import core_pkg::*;

    logic [xlen-1:0] mem [mem_words];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // Registered read lands in the writeback cycle
    always_ff @(posedge clk_i) begin
        rdata_o <= mem[addr_i];
    end

endmodule

// File: pipe_core.sv
// Four-stage pipeline core
`timescale 1ns/1ps

module pipe_core (
    input  logic             clk_i,
    input  logic             rst_i,
    input  core_pkg::instr_t instr_i,
    input  logic             instr_valid_i,  // Fetch ready level
    input  logic             flush_i,        // Mispredict pulse
    output logic             fetch_stall_o,
    output pipe_pkg::wb_t    wb_o
);
    import core_pkg::*;
    import pipe_pkg::*;

    instr_t            f_instr;
    logic              f_valid;
    dx_t               dx_d;
    dx_t               dx_q;
    logic              dx_valid;
    xw_t               xw_d;
    xw_t               xw_q;
    logic              xw_valid;
    reg_addr_t         dec_rs1;
    reg_addr_t         dec_rs2;
    fwd_sel_e          fwd_sel1;
    fwd_sel_e          fwd_sel2;
    logic              fetch_flush;
    logic              dec_stall;
    logic              dec_flush;
    logic              ex_ready;
    logic              ex_fwd_valid;
    logic [xlen-1:0]   ex_result;
    logic [xlen-1:0]   rf_data1;
    logic [xlen-1:0]   rf_data2;
    logic              mem_we;
    logic [mem_aw-1:0] mem_addr;
    logic [xlen-1:0]   mem_wdata;
    logic [xlen-1:0]   mem_rdata;

    hazard_ctrl u_hazard (
        .clk_i(clk_i), .rst_i(rst_i), .mispredict_i(flush_i), .fetch_ready_i(f_valid),
        .dec_rs1_i(dec_rs1), .dec_rs2_i(dec_rs2), .ex_wr_i(dx_q.wr), .ex_rd_i(dx_q.rd),
        .ex_ready_i(ex_ready), .ex_fwd_valid_i(ex_fwd_valid),
        .wb_wr_i(wb_o.valid), .wb_rd_i(wb_o.rd),
        .fwd_sel1_o(fwd_sel1), .fwd_sel2_o(fwd_sel2), .fetch_stall_o(fetch_stall_o),
        .fetch_flush_o(fetch_flush), .dec_stall_o(dec_stall), .dec_flush_o(dec_flush)
    );

    stage_reg #(.payload_t(instr_t)) u_fetch_reg (
        .clk_i(clk_i), .rst_i(rst_i), .hold_i(fetch_stall_o), .kill_i(fetch_flush),
        .d_i(instr_i), .d_valid_i(instr_valid_i), .q_o(f_instr), .q_valid_o(f_valid)
    );

    reg_file u_rf (
        .clk_i(clk_i), .rd_addr1_i(dec_rs1), .rd_addr2_i(dec_rs2), .wb_i(wb_o),
        .rd_data1_o(rf_data1), .rd_data2_o(rf_data2)
    );

    decode_stage u_decode (
        .instr_i(f_instr), .instr_valid_i(f_valid), .rf_data1_i(rf_data1),
        .rf_data2_i(rf_data2), .fwd_sel1_i(fwd_sel1), .fwd_sel2_i(fwd_sel2),
        .ex_result_i(ex_result), .wb_data_i(wb_o.data),
        .rs1_o(dec_rs1), .rs2_o(dec_rs2), .dx_o(dx_d)
    );

    // Busy execute holds its entry, a flush only drops the incoming one
    stage_reg #(.payload_t(dx_t)) u_dx_reg (
        .clk_i(clk_i), .rst_i(rst_i), .hold_i(!ex_ready), .kill_i(dec_flush && ex_ready),
        .d_i(dx_d), .d_valid_i(f_valid && !dec_stall), .q_o(dx_q), .q_valid_o(dx_valid)
    );

    exec_unit u_exec (
        .clk_i(clk_i), .rst_i(rst_i), .dx_i(dx_q), .dx_valid_i(dx_valid), .xw_o(xw_d),
        .ready_o(ex_ready), .fwd_valid_o(ex_fwd_valid), .result_o(ex_result),
        .mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata)
    );

    data_mem u_dmem (
        .clk_i(clk_i), .rst_i(rst_i), .we_i(mem_we), .addr_i(mem_addr),
        .wdata_i(mem_wdata), .rdata_o(mem_rdata)
    );

    stage_reg #(.payload_t(xw_t)) u_xw_reg (
        .clk_i(clk_i), .rst_i(rst_i), .hold_i(1'b0), .kill_i(!ex_ready),
        .d_i(xw_d), .d_valid_i(dx_valid), .q_o(xw_q), .q_valid_o(xw_valid)
    );

    always_comb begin
        wb_o.valid = xw_valid && xw_q.wr;
        wb_o.rd    = xw_q.rd;
        wb_o.data  = xw_q.is_load ? mem_rdata : xw_q.result;  // Load value from memory
    end

endmodule

// File: pipe_core_chk.sv
// Pipeline control assertions
`timescale 1ns/1ps

module pipe_core_chk (
    input logic                clk_i,
    input logic                rst_i,
    input logic                ex_ready_i,
    input logic                fetch_stall_i,
    input core_pkg::reg_addr_t dec_rs1_i,
    input core_pkg::reg_addr_t dec_rs2_i,
    input pipe_pkg::fwd_sel_e  fwd_sel1_i,
    input pipe_pkg::fwd_sel_e  fwd_sel2_i,
    input pipe_pkg::wb_t       wb_i
);
    import pipe_pkg::*;

    a_no_wb_in_reset: assert property (@(posedge clk_i) $past(rst_i) |-> !wb_i.valid)
        else $error("Writeback valid during reset or in the cycle after it");

    a_x0_rs1_no_fwd: assert property (@(posedge clk_i) disable iff (rst_i)
        (dec_rs1_i == '0) |-> (fwd_sel1_i == fwd_none))
        else $error("Forward selected for rs1 reading x0");

    a_x0_rs2_no_fwd: assert property (@(posedge clk_i) disable iff (rst_i)
        (dec_rs2_i == '0) |-> (fwd_sel2_i == fwd_none))
        else $error("Forward selected for rs2 reading x0");

    // Busy execute must hold the front end
    a_busy_stalls: assert property (@(posedge clk_i) disable iff (rst_i)
        !ex_ready_i |-> fetch_stall_i)
        else $error("Fetch not stalled while execute is busy");

    a_no_x0_wb: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_i.valid |-> (wb_i.rd != '0))
        else $error("Writeback to x0 with valid high");

endmodule

bind pipe_core pipe_core_chk u_chk (
    .clk_i(clk_i), .rst_i(rst_i), .ex_ready_i(ex_ready), .fetch_stall_i(fetch_stall_o),
    .dec_rs1_i(dec_rs1), .dec_rs2_i(dec_rs2), .fwd_sel1_i(fwd_sel1), .fwd_sel2_i(fwd_sel2),
    .wb_i(wb_o)
);

// File: pipe_core_tb.sv
// Pipeline core testbench
`timescale 1ns/1ps

module pipe_core_tb;
    import core_pkg::*;
    import pipe_pkg::*;

    localparam int n_rows       = 20;
    localparam int rst_cycles   = 16;
    localparam int row_budget   = 40;  // Cycles allowed per row
    localparam int drain_cycles = 8;
    localparam int f_expect     = 0;   // Flag bits above the data field
    localparam int f_flush      = 1;
    localparam int f_wrong      = 2;

    logic        clk;
    logic        rst;
    instr_t      instr;
    logic        instr_valid;
    logic        flush;
    logic        fetch_stall;
    wb_t         wb;
    logic [67:0] rows [n_rows];       // {instr, flags, expected data}
    logic [36:0] exp_q [$];           // {rd, data} in program order
    logic [31:0] rng_state;

    pipe_core dut (
        .clk_i(clk), .rst_i(rst), .instr_i(instr), .instr_valid_i(instr_valid),
        .flush_i(flush), .fetch_stall_o(fetch_stall), .wb_o(wb)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_equal(input logic [36:0] got, input logic [36:0] exp,
                               input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %t: %s got x%0d = %h, expected x%0d = %h",
                                $time, what, got[36:32], got[31:0], exp[36:32], exp[31:0]));
        end
    endtask

    // Random idle gap, then hold the row until fetch takes it
    task automatic issue_row(input logic [67:0] row);
        int   gap;
        logic accepted;
        rng_state = xorshift(rng_state);
        gap = int'(rng_state[1:0]);
        repeat (gap) @(negedge clk);
        instr       = instr_t'(row[36 +: $bits(instr_t)]);
        instr_valid = 1'b1;
        accepted    = 1'b0;
        while (!accepted) begin
            accepted = !fetch_stall;  // Taken at the coming rising edge
            @(negedge clk);
        end
        instr_valid = 1'b0;
        if (row[32 + f_expect] && !row[32 + f_wrong]) begin
            exp_q.push_back({instr.rd, row[31:0]});
        end
        if (row[32 + f_flush]) begin
            flush = 1'b1;  // Kills the row now sitting in decode
            @(negedge clk);
            flush = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && wb.valid) begin
            if (exp_q.size() == 0) begin
                abort_run($sformatf("Unexpected writeback to x%0d with nothing pending",
                                    wb.rd));
            end else begin
                check_equal({wb.rd, wb.data}, exp_q.pop_front(), "writeback");
            end
        end
    end

    initial begin : watchdog
        repeat (rst_cycles + n_rows * row_budget) @(posedge clk);
        abort_run($sformatf("Timeout: %0d writebacks never arrived", exp_q.size()));
    end

    initial begin
        $timeformat(-9, 1, " ns", 0);
        clk         = 1'b0;
        rst         = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        flush       = 1'b0;
        rng_state   = 32'h7484;
        $readmemh("program_input.txt", rows);
        repeat (rst_cycles) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);  // Skip the start flush
        check_equal(37'(fetch_stall), 37'd0, "fetch stall with idle pipeline");
        for (int i = 0; i < n_rows; i++) begin
            issue_row(rows[i]);
        end
        while (exp_q.size() != 0) @(negedge clk);
        repeat (drain_cycles) @(negedge clk);  // Catch late stray writebacks
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: program_input.txt
// Columns: instruction (8 hex) _ flags (1 hex) _ expected writeback data (8 hex)
// Flags: bit0 expects writeback, bit1 flush after accept, bit2 wrong path
204007F3_1_000007F3  // ADDI x1, x0, 0x7F3
20800FFA_1_FFFFFFFA  // ADDI x2, x0, -6
00C22000_1_000007ED  // ADD  x3, x1, x2
09061000_1_FFFFFFFA  // SUB  x4, x3, x1
11483000_1_000007E8  // AND  x5, x4, x3
198A2000_1_FFFFF812  // XOR  x6, x5, x2
29C21000_1_003F30A9  // MUL  x7, x1, x1
2A0C2000_1_00002F94  // MUL  x8, x6, x2
02507000_1_003F603D  // ADD  x9, x8, x7
38009003_0_00000000  // ST   x9, 3(x0)
32800003_1_003F603D  // LD   x10, 3(x0)
02D41000_1_003F6830  // ADD  x11, x10, x1
20400123_6_00000000  // ADDI x1, x0, 0x123 wrong path
00C00000_6_00000000  // ADD  x3, x0, x0 wrong path
03023000_1_00000FE0  // ADD  x12, x1, x3
20000055_0_00000000  // ADDI x0, x0, 0x55
0340C000_1_00000FE0  // ADD  x13, x0, x12
2B9A5000_1_007D8300  // MUL  x14, x13, x5
2BDC0000_1_00000000  // MUL  x15, x14, x0
34000005_1_00000000  // LD   x16, 5(x0)

// File: list.f
core_pkg.sv
pipe_pkg.sv
hazard_ctrl.sv
stage_reg.sv
reg_file.sv
decode_stage.sv
exec_unit.sv
data_mem.sv
pipe_core.sv
pipe_core_chk.sv
pipe_core_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= pipe_core_tb
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
BUILD_OPTS ?= --binary --timing --assert -j 0
FAIL_MSG   ?= *** TEST FAILED ***
PASS_MSG   ?= *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(BUILD_OPTS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "No pass result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
